// ==== build.f ====
+incdir+testbench
common/game_pkg.sv
game_control/game_control.sv
data_game_flow/map_memory.sv
data_game_flow/screen_painter.sv
data_game_flow/car_engine.sv
data_game_flow/tower_painter.sv
data_game_flow/data_game_flow.sv
verilog/tower_defense_top.sv
testbench/tb_tower_defense.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds and runs the tower defence testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -f build.f --top-module tb_tower_defense \
	-o tb_tower_defense > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
	cat "$BUILD_LOG"
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_tower_defense > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -qF "** FAIL **" "$SIM_LOG"; then
	exit 1
fi
exit 0

// ==== testbench/tb_tasks.svh ====
// Power up map, grass with the road band
task automatic init_model_map();
	for (int i = 0; i < SCREEN_PIXELS; i++)
		model_map[i] = (i / SCREEN_W >= ROAD_Y0 && i / SCREEN_W <= ROAD_Y1) ? COL_ROAD : COL_GRASS;
endtask

// Colour a redraw must show at raster index idx
function automatic colour_t screen_colour(scene_t sc, stage_t st, int idx);
	int row;
	row = idx / SCREEN_W;
	if (sc == SCENE_STAGE && (row == 0 || row == SCREEN_H - 1))
		return COL_STAGE[st]; // Stage border rows
	return model_map[idx];
endfunction

task automatic check_pixel(string what, pixel_t got, pixel_t exp);
	if (got !== exp) begin
		$display("Error: pixel (%s) got coord %h colour %h, expected coord %h colour %h",
			what, got.coord, got.colour, exp.coord, exp.colour);
		err_cnt++;
	end
endtask

task automatic check_phase(phase_t got, phase_t exp);
	if (got !== exp) begin
		$display("Error: phase got %h expected %h", got, exp);
		err_cnt++;
	end
endtask

task automatic check_count(string what, int got, int exp);
	if (got != exp) begin
		$display("Error: %s got %h expected %h", what, got, exp);
		err_cnt++;
	end
endtask

task automatic report_timeout(string what);
	$display("Timed out while waiting for %s", what);
	err_cnt++;
	timed_out = 1'b1;
endtask

task automatic open_test();
	err_mark = err_cnt;
endtask

task automatic close_test(string name);
	tests_run++;
	if (err_cnt == err_mark) begin
		$display("Test %0d %s: ok", tests_run, name);
	end else begin
		tests_failed++;
		$display("Test %0d %s: failed with %0d errors", tests_run, name, err_cnt - err_mark);
	end
endtask

task automatic apply_reset();
	arst_n   = 1'b0;
	start    = 1'b0;
	go_down  = 1'b0;
	go_right = 1'b0;
	go_draw  = 1'b0;
	repeat (10) @(negedge clk);
	arst_n = 1'b1;
endtask

task automatic wait_phase(phase_t want, int limit);
	int n;
	n = 0;
	while (phase !== want && n < limit) begin
		@(negedge clk);
		n++;
	end
	if (phase !== want)
		report_timeout($sformatf("phase %s", want.name()));
endtask

task automatic hold_phase(phase_t want, int cycles);
	repeat (cycles) begin
		@(negedge clk);
		check_phase(phase, want);
	end
endtask

// Pulse start and see the intro begin
task automatic start_game();
	@(negedge clk);
	start = 1'b1;
	wait_phase(PH_INTRO, WAIT_LIMIT);
	start = 1'b0;
endtask

// Collect one full redraw and compare every write
task automatic check_screen(scene_t sc, stage_t st, phase_t ph);
	int     n;
	int     cyc;
	pixel_t exp;
	n   = 0;
	cyc = 0;
	while (n < SCREEN_PIXELS && cyc < PAINT_LIMIT) begin
		@(negedge clk);
		cyc++;
		if (pixel.wren) begin
			exp = '{wren: 1'b1, coord: coord_t'(n), colour: screen_colour(sc, st, n)};
			check_pixel("screen", pixel, exp);
			if (n == 0)
				check_phase(phase, ph);
			n++;
		end
	end
	if (n < SCREEN_PIXELS)
		report_timeout("the end of a screen redraw");
endtask

task automatic move_right();
	@(negedge clk);
	go_right = 1'b1;
	@(negedge clk);
	go_right = 1'b0;
	cur_x = (cur_x >= xpos_t'(SCREEN_W - 8)) ? xpos_t'(SCREEN_W - 8) : cur_x + 8'd8;
endtask

task automatic move_down();
	@(negedge clk);
	go_down = 1'b1;
	@(negedge clk);
	go_down = 1'b0;
	cur_y = (cur_y >= ypos_t'(SCREEN_H - 8)) ? ypos_t'(SCREEN_H - 8) : cur_y + 7'd8;
endtask

// Draw at the predicted cursor, 16 writes back to back
task automatic place_tower();
	int     n;
	int     cyc;
	int     idx;
	pixel_t exp;
	@(negedge clk);
	go_draw = 1'b1;
	n   = 0;
	cyc = 0;
	while (n < TOWER_SIZE * TOWER_SIZE && cyc < WAIT_LIMIT) begin
		@(negedge clk);
		go_draw = 1'b0;
		cyc++;
		if (pixel.wren) begin
			idx = (int'(cur_y) + n / TOWER_SIZE) * SCREEN_W + int'(cur_x) + n % TOWER_SIZE;
			exp = '{wren: 1'b1, coord: coord_t'(idx), colour: COL_TOWER};
			check_pixel("tower", pixel, exp);
			model_map[idx] = COL_TOWER; // Map gets the same write
			n++;
		end
	end
	if (n < TOWER_SIZE * TOWER_SIZE)
		report_timeout("the tower writes");
	check_count("tower draw cycles", cyc, TOWER_SIZE * TOWER_SIZE);
	if (int'(cur_y) + TOWER_SIZE - 1 >= ROAD_Y0 && int'(cur_y) <= ROAD_Y1)
		tower_cols.push_back(cur_x); // Touches the road
endtask

task automatic build_stage(int r1, int d1, int r2, int d2);
	wait_phase(PH_BUILD, WAIT_LIMIT);
	repeat (3) @(negedge clk); // Painter takes the request
	cur_x = '0;
	cur_y = ypos_t'(ROAD_Y0 - 8);
	repeat (r1) move_right();
	repeat (d1) move_down();
	place_tower();
	repeat (r2) move_right();
	repeat (d2) move_down();
	place_tower();
	wait_phase(PH_BATTLE, WAIT_LIMIT);
endtask

// Watch car writes until the battle phase ends
task automatic run_battle(logic expect_lost, phase_t next_ph);
	int   cyc;
	int   col;
	int   writes;
	logic reached_end;
	wait_phase(PH_BATTLE, WAIT_LIMIT);
	cyc         = 0;
	writes      = 0;
	reached_end = 1'b0;
	while (phase == PH_BATTLE && cyc < BATTLE_LIMIT) begin
		@(negedge clk);
		cyc++;
		if (pixel.wren) begin
			writes++;
			col = int'(pixel.coord) % SCREEN_W;
			check_count("car write row", int'(pixel.coord) / SCREEN_W, CAR_ROW);
			if (pixel.colour !== COL_CAR && pixel.colour !== COL_ROAD) begin
				$display("Error: pixel colour %h is neither car %h nor road %h",
					pixel.colour, COL_CAR, COL_ROAD);
				err_cnt++;
			end
			if (col == SCREEN_W - 1)
				reached_end = 1'b1;
			if (pixel.colour == COL_CAR)
				foreach (tower_cols[i])
					if (col >= int'(tower_cols[i]) && col < int'(tower_cols[i]) + TOWER_SIZE) begin
						$display("A car was drawn at column %0d inside a tower", col);
						err_cnt++;
					end
		end
	end
	if (phase == PH_BATTLE)
		report_timeout("the end of a battle");
	if (writes == 0) begin
		$display("No car was drawn during the battle");
		err_cnt++;
	end
	check_count("car at last column", int'(reached_end), int'(expect_lost));
	check_phase(phase, next_ph);
endtask

task automatic test_reset_idle();
	int w;
	open_test();
	w = 0;
	repeat (20) begin
		@(negedge clk);
		check_phase(phase, PH_IDLE);
		if (pixel.wren)
			w++;
		{go_down, go_right, go_draw} = 3'($random(seed)); // Buttons must be ignored
	end
	go_down  = 1'b0;
	go_right = 1'b0;
	go_draw  = 1'b0;
	check_count("writes while idle", w, 0);
	close_test("reset and idle");
endtask

task automatic test_start_intro();
	open_test();
	start_game();
	check_screen(SCENE_INTRO, 2'd0, PH_INTRO);
	check_screen(SCENE_STAGE, 2'd0, PH_STAGE_SCREEN);
	close_test("start, intro and stage 0 screen");
endtask

task automatic test_build_random();
	int r1;
	int r2;
	int d2;
	open_test();
	r1 = 1 + int'($unsigned($random(seed)) % 15); // Never column 0
	r2 = int'($unsigned($random(seed)) % 16);     // Can saturate
	d2 = int'($unsigned($random(seed)) % 2);
	build_stage(r1, 1, r2, d2); // First tower on the road
	close_test("build with random moves");
endtask

task automatic test_battle_cleared();
	open_test();
	run_battle(1'b0, PH_STAGE_SCREEN);
	check_screen(SCENE_STAGE, 2'd1, PH_STAGE_SCREEN); // Towers now in the map
	close_test("battle cleared");
endtask

task automatic test_all_stages();
	open_test();
	build_stage(3, 1, 2, 0);
	run_battle(1'b0, PH_STAGE_SCREEN);
	check_screen(SCENE_STAGE, 2'd2, PH_STAGE_SCREEN);
	build_stage(6, 0, 4, 0);
	run_battle(1'b0, PH_WIN);
	hold_phase(PH_WIN, 50);
	close_test("all stages cleared");
endtask

task automatic test_battle_lost();
	open_test();
	@(negedge clk);
	apply_reset();
	tower_cols.delete(); // Map keeps its towers
	start_game();
	check_screen(SCENE_INTRO, 2'd0, PH_INTRO);
	check_screen(SCENE_STAGE, 2'd0, PH_STAGE_SCREEN);
	build_stage(2, 0, 3, 0); // Both above the road
	run_battle(1'b1, PH_LOSE);
	hold_phase(PH_LOSE, 20);
	close_test("battle lost");
endtask

// ==== testbench/tb_tower_defense.sv ====
`timescale 1ns/1ns

module tb_tower_defense;
	import game_pkg::*;

	localparam int WAIT_LIMIT   = 200;                 // Cycles for a phase change
	localparam int PAINT_LIMIT  = SCREEN_PIXELS + 200; // One redraw plus start up
	localparam int BATTLE_LIMIT = 20000;

	logic    clk;
	logic    arst_n;
	logic    start;
	logic    go_down;
	logic    go_right;
	logic    go_draw;
	pixel_t  pixel;
	phase_t  phase;

	integer  seed = 49;
	int      err_cnt;
	int      err_mark;     // Errors when the current test began
	int      tests_run;
	int      tests_failed;
	logic    timed_out;
	colour_t model_map [SCREEN_PIXELS]; // Expected map memory contents
	xpos_t   tower_cols [$];            // Towers that stop cars
	xpos_t   cur_x;                     // Predicted cursor
	ypos_t   cur_y;

	tower_defense_top tower_defense_top_inst (
		.clk, .arst_n, .start, .go_down, .go_right, .go_draw, .pixel, .phase
	);

	always #10 clk = ~clk; // 20 ns period

	`include "tb_tasks.svh"

	initial begin
		clk          = 1'b0;
		arst_n       = 1'b0;
		start        = 1'b0;
		go_down      = 1'b0;
		go_right     = 1'b0;
		go_draw      = 1'b0;
		err_cnt      = 0;
		err_mark     = 0;
		tests_run    = 0;
		tests_failed = 0;
		timed_out    = 1'b0;
		cur_x        = '0;
		cur_y        = '0;
		init_model_map();
		apply_reset();
		test_reset_idle();
		if (!timed_out)
			test_start_intro();
		if (!timed_out)
			test_build_random();
		if (!timed_out)
			test_battle_cleared();
		if (!timed_out)
			test_all_stages();
		if (!timed_out)
			test_battle_lost();
		$display("Summary: %0d tests run, %0d failed, %0d errors",
			tests_run, tests_failed, err_cnt);
		if (err_cnt == 0 && !timed_out)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

// ==== verilog/tower_defense_top.sv ====
`timescale 1ns/1ns

module tower_defense_top (
	input  logic             clk,
	input  logic             arst_n,
	input  logic             start,
	input  logic             go_down,
	input  logic             go_right,
	input  logic             go_draw,
	output game_pkg::pixel_t pixel,
	output game_pkg::phase_t phase
);
	import game_pkg::*;

	logic   paint_req;
	logic   paint_ack;
	logic   build_req;
	logic   build_ack;
	logic   battle_req;
	logic   battle_ack;
	logic   battle_lost;
	scene_t scene;
	stage_t stage;

	game_control game_control_inst (
		.clk, .arst_n, .start, .paint_ack, .build_ack, .battle_ack, .battle_lost,
		.paint_req, .build_req, .battle_req, .scene, .stage, .phase
	);

	data_game_flow data_game_flow_inst (
		.clk, .arst_n, .go_down, .go_right, .go_draw, .paint_req, .build_req,
		.battle_req, .scene, .stage, .paint_ack, .build_ack, .battle_ack,
		.battle_lost, .pixel
	);

endmodule

// ==== data_game_flow/data_game_flow.sv ====
`timescale 1ns/1ns

module data_game_flow (
	input  logic             clk,
	input  logic             arst_n,
	input  logic             go_down,
	input  logic             go_right,
	input  logic             go_draw,
	input  logic             paint_req,
	input  logic             build_req,
	input  logic             battle_req,
	input  game_pkg::scene_t scene,
	input  game_pkg::stage_t stage,
	output logic             paint_ack,
	output logic             build_ack,
	output logic             battle_ack,
	output logic             battle_lost,
	output game_pkg::pixel_t pixel
);
	import game_pkg::*;

	pixel_t     tower_px;
	pixel_t     car_px;
	pixel_t     screen_px;
	logic       tower_map_we;
	coord_t     tower_map_addr;
	coord_t     screen_map_addr;
	coord_t     map_addr;
	colour_t    map_q;
	tower_set_t towers; // Shared with the car engine

	tower_painter tower_painter_inst (
		.clk, .arst_n, .go_down, .go_right, .go_draw, .build_req, .build_ack,
		.pixel(tower_px), .map_we(tower_map_we), .map_addr(tower_map_addr), .towers
	);

	car_engine car_engine_inst (
		.clk, .arst_n, .battle_req, .stage, .towers, .battle_ack, .battle_lost,
		.pixel(car_px)
	);

	screen_painter screen_painter_inst (
		.clk, .arst_n, .paint_req, .scene, .stage, .map_q, .paint_ack,
		.map_addr(screen_map_addr), .pixel(screen_px)
	);

	// Towers get the map port while they draw
	assign map_addr = tower_map_we ? tower_map_addr : screen_map_addr;

	map_memory map_memory_inst (
		.clk, .addr(map_addr), .we(tower_map_we), .wdata(tower_px.colour), .q(map_q)
	);

	// Tower beats car beats screen
	always_comb begin
		if (tower_px.wren)       pixel = tower_px;
		else if (car_px.wren)    pixel = car_px;
		else if (screen_px.wren) pixel = screen_px;
		else                     pixel = '0;
	end

	assert property (@(posedge clk) disable iff (!arst_n)
		$onehot0({tower_px.wren, car_px.wren, screen_px.wren}));

	// Tower writes never land inside a screen redraw
	assert property (@(posedge clk) disable iff (!arst_n)
		tower_map_we |-> !paint_req);

endmodule

// ==== data_game_flow/tower_painter.sv ====
`timescale 1ns/1ns

module tower_painter (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 go_down,
	input  logic                 go_right,
	input  logic                 go_draw,
	input  logic                 build_req,
	output logic                 build_ack,
	output game_pkg::pixel_t     pixel,
	output logic                 map_we,
	output game_pkg::coord_t     map_addr,
	output game_pkg::tower_set_t towers
);
	import game_pkg::*;

	typedef enum logic [1:0] {TP_IDLE, TP_MOVE, TP_DRAW, TP_ACK} tp_state_t;

	tp_state_t  state;
	logic [2:0] btn_q;  // Down, right, draw of the last cycle
	logic       rise_down;
	logic       rise_right;
	logic       rise_draw;
	xpos_t      cur_x;
	ypos_t      cur_y;
	logic [3:0] cnt;    // Pixel inside the block, row major
	logic [1:0] placed; // Towers drawn this stage
	logic       on_road;
	xpos_t      draw_x;
	ypos_t      draw_y;

	assign rise_down  = go_down && !btn_q[2];
	assign rise_right = go_right && !btn_q[1];
	assign rise_draw  = go_draw && !btn_q[0];

	// Only towers touching the road rows can stop cars
	assign on_road = (cur_y + ypos_t'(TOWER_SIZE - 1) >= ypos_t'(ROAD_Y0))
		&& (cur_y <= ypos_t'(ROAD_Y1));

	assign draw_x = cur_x + xpos_t'(cnt[1:0]);
	assign draw_y = cur_y + ypos_t'(cnt[3:2]);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state  <= TP_IDLE;
			btn_q  <= '0;
			cur_x  <= '0;
			cur_y  <= '0;
			cnt    <= '0;
			placed <= '0;
			towers <= '0; // Kept over all stages
		end else begin
			btn_q <= {go_down, go_right, go_draw};
			case (state)
				TP_IDLE: if (build_req) begin
					cur_x  <= '0;
					cur_y  <= ypos_t'(ROAD_Y0 - CURSOR_STEP);
					placed <= '0;
					state  <= TP_MOVE;
				end
				TP_MOVE: begin
					if (rise_draw) begin
						cnt   <= '0;
						state <= TP_DRAW;
						if (on_road && towers.count < 3'(MAX_TOWERS)) begin
							towers.col[towers.count] <= cur_x;
							towers.count             <= towers.count + 3'd1;
						end
					end else begin // Moves wait while a draw is taken
						if (rise_right)
							cur_x <= (cur_x >= xpos_t'(SCREEN_W - CURSOR_STEP)) ?
								xpos_t'(SCREEN_W - CURSOR_STEP) : cur_x + xpos_t'(CURSOR_STEP);
						if (rise_down)
							cur_y <= (cur_y >= ypos_t'(SCREEN_H - CURSOR_STEP)) ?
								ypos_t'(SCREEN_H - CURSOR_STEP) : cur_y + ypos_t'(CURSOR_STEP);
					end
				end
				TP_DRAW: begin
					cnt <= cnt + 4'd1;
					if (cnt == 4'(TOWER_SIZE * TOWER_SIZE - 1)) begin
						placed <= placed + 2'd1;
						state  <= (placed == 2'(TOWERS_PER_STAGE - 1)) ? TP_ACK : TP_MOVE;
					end
				end
				default: if (!build_req) state <= TP_IDLE; // Ack held until req drops
			endcase
		end
	end

	assign pixel     = '{wren: (state == TP_DRAW), coord: pix_addr(draw_y, draw_x),
		colour: COL_TOWER};
	assign map_we    = pixel.wren; // Same write into the map
	assign map_addr  = pixel.coord;
	assign build_ack = (state == TP_ACK);

endmodule

// ==== data_game_flow/car_engine.sv ====
`timescale 1ns/1ns

module car_engine (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 battle_req,
	input  game_pkg::stage_t     stage,
	input  game_pkg::tower_set_t towers,
	output logic                 battle_ack,
	output logic                 battle_lost,
	output game_pkg::pixel_t     pixel
);
	import game_pkg::*;

	typedef enum logic [2:0] {CE_IDLE, CE_WAIT, CE_ERASE, CE_DRAW, CE_CHECK, CE_ACK} ce_state_t;
	typedef struct packed {
		logic  alive;
		logic  fresh; // Launched, not on screen yet
		xpos_t col;
	} car_t;

	ce_state_t           state;
	car_t [MAX_CARS-1:0] cars;
	logic [1:0]          sl;       // Slot of the pass
	step_cnt_t           div;
	gap_cnt_t            gap;      // Steps left to next launch
	logic [1:0]          launched;
	logic [1:0]          n_cars;
	logic                lost_q;
	car_t                cur;
	xpos_t               target;   // Column the car moves to
	logic                hit;
	logic                any_alive;

	assign n_cars = stage + 2'd1; // Stage n runs n+1 cars

	always_comb begin
		cur    = cars[sl];
		target = cur.fresh ? cur.col : cur.col + 8'd1;
		hit    = 1'b0;
		for (int i = 0; i < MAX_TOWERS; i++) begin
			if (3'(i) < towers.count && target >= towers.col[i]
				&& target <= towers.col[i] + xpos_t'(TOWER_SIZE - 1))
				hit = 1'b1;
		end
	end

	always_comb begin
		any_alive = 1'b0;
		for (int i = 0; i < MAX_CARS; i++)
			any_alive = any_alive | cars[i].alive;
	end

	// A step is the divider wait and then one erase and draw pair per slot
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state    <= CE_IDLE;
			cars     <= '0;
			sl       <= '0;
			div      <= '0;
			gap      <= '0;
			launched <= '0;
			lost_q   <= 1'b0;
		end else begin
			case (state)
				CE_IDLE: if (battle_req) begin
					cars     <= '0;
					div      <= '0;
					gap      <= '0; // First car on the first step
					launched <= '0;
					lost_q   <= 1'b0;
					state    <= CE_WAIT;
				end
				CE_WAIT: begin
					div <= div + 1'b1;
					if (div == step_cnt_t'(CAR_STEP_CYCLES - 1)) begin
						div   <= '0;
						sl    <= '0;
						state <= CE_ERASE;
						if (gap == '0 && launched < n_cars) begin
							cars[launched] <= '{alive: 1'b1, fresh: 1'b1, col: '0};
							launched       <= launched + 2'd1;
							gap            <= gap_cnt_t'(CAR_GAP - 1);
						end else if (gap != '0) begin
							gap <= gap - 1'b1;
						end
					end
				end
				CE_ERASE: state <= CE_DRAW;
				CE_DRAW: begin
					if (cur.alive && hit) begin
						cars[sl].alive <= 1'b0; // Stopped at a tower
					end else if (cur.alive) begin
						cars[sl].col   <= target;
						cars[sl].fresh <= 1'b0;
						if (target == xpos_t'(SCREEN_W - 1))
							lost_q <= 1'b1; // Broke through
					end
					sl    <= sl + 2'd1;
					state <= (sl == 2'(MAX_CARS - 1)) ? CE_CHECK : CE_ERASE;
				end
				CE_CHECK: begin
					if (lost_q || (launched == n_cars && !any_alive))
						state <= CE_ACK;
					else
						state <= CE_WAIT;
				end
				default: if (!battle_req) state <= CE_IDLE;
			endcase
		end
	end

	always_comb begin
		pixel = '0;
		if (state == CE_ERASE) begin
			pixel = '{wren: cur.alive && !cur.fresh, coord: pix_addr(ypos_t'(CAR_ROW), cur.col),
				colour: COL_ROAD};
		end else if (state == CE_DRAW) begin
			pixel = '{wren: cur.alive && !hit, coord: pix_addr(ypos_t'(CAR_ROW), target),
				colour: COL_CAR};
		end
	end

	assign battle_ack  = (state == CE_ACK);
	assign battle_lost = battle_ack && lost_q; // Only meaningful with ack

endmodule

// ==== data_game_flow/screen_painter.sv ====
`timescale 1ns/1ns

module screen_painter (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              paint_req,
	input  game_pkg::scene_t  scene,
	input  game_pkg::stage_t  stage,
	input  game_pkg::colour_t map_q,
	output logic              paint_ack,
	output game_pkg::coord_t  map_addr,
	output game_pkg::pixel_t  pixel
);
	import game_pkg::*;

	typedef enum logic [1:0] {SP_IDLE, SP_RUN, SP_DRAIN, SP_ACK} sp_state_t;

	sp_state_t state;
	xpos_t     x_q;
	ypos_t     y_q;
	logic      last;    // Bottom right pixel being read
	logic      valid_d; // Read data is on map_q
	coord_t    addr_d;
	ypos_t     y_d;
	logic      border;

	assign map_addr = pix_addr(y_q, x_q);
	assign last     = (x_q == xpos_t'(SCREEN_W - 1)) && (y_q == ypos_t'(SCREEN_H - 1));

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state   <= SP_IDLE;
			x_q     <= '0;
			y_q     <= '0;
			valid_d <= 1'b0;
		end else begin
			valid_d <= (state == SP_RUN);
			case (state)
				SP_IDLE: if (paint_req) begin
					x_q   <= '0;
					y_q   <= '0;
					state <= SP_RUN;
				end
				SP_RUN: begin
					if (last) begin
						state <= SP_DRAIN;
					end else if (x_q == xpos_t'(SCREEN_W - 1)) begin
						x_q <= '0; // Next raster line
						y_q <= y_q + 7'd1;
					end else begin
						x_q <= x_q + 8'd1;
					end
				end
				SP_DRAIN: state <= SP_ACK; // Last pixel leaves now
				default: if (!paint_req) state <= SP_IDLE;
			endcase
		end
	end

	// Aligned with the memory latency
	always_ff @(posedge clk) begin
		addr_d <= map_addr;
		y_d    <= y_q;
	end

	// Stage screens get a coloured top and bottom row
	assign border = (scene == SCENE_STAGE)
		&& (y_d == '0 || y_d == ypos_t'(SCREEN_H - 1));

	assign pixel     = '{wren: valid_d, coord: addr_d,
		colour: border ? COL_STAGE[stage] : map_q};
	assign paint_ack = (state == SP_ACK);

endmodule

// ==== data_game_flow/map_memory.sv ====
`timescale 1ns/1ns

module map_memory (
	input  logic              clk,
	input  game_pkg::coord_t  addr,
	input  logic              we,
	input  game_pkg::colour_t wdata,
	output game_pkg::colour_t q
);
	import game_pkg::*;

	colour_t mem [SCREEN_PIXELS];

	// Background: grass with a horizontal road
	initial begin
		for (int i = 0; i < SCREEN_PIXELS; i++) begin
			if (i / SCREEN_W >= ROAD_Y0 && i / SCREEN_W <= ROAD_Y1)
				mem[i] = COL_ROAD;
			else
				mem[i] = COL_GRASS;
		end
	end

	always @(posedge clk) begin
		if (we)
			mem[addr] <= wdata;
		q <= mem[addr]; // Old data on a write cycle
	end

endmodule

// ==== game_control/game_control.sv ====
`timescale 1ns/1ns

module game_control (
	input  logic             clk,
	input  logic             arst_n,
	input  logic             start,
	input  logic             paint_ack,
	input  logic             build_ack,
	input  logic             battle_ack,
	input  logic             battle_lost,
	output logic             paint_req,
	output logic             build_req,
	output logic             battle_req,
	output game_pkg::scene_t scene,
	output game_pkg::stage_t stage,
	output game_pkg::phase_t phase
);
	import game_pkg::*;

	logic req_q;  // Request of the phase we are in
	logic lost_q; // Sampled with the battle ack
	logic ack;    // Ack that belongs to the current phase

	always_comb begin
		case (phase)
			PH_INTRO, PH_STAGE_SCREEN: ack = paint_ack;
			PH_BUILD:                  ack = build_ack;
			PH_BATTLE:                 ack = battle_ack;
			default:                   ack = 1'b0;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			phase  <= PH_IDLE;
			stage  <= '0;
			req_q  <= 1'b0;
			lost_q <= 1'b0;
		end else begin
			case (phase)
				PH_IDLE: if (start) begin
					phase <= PH_INTRO;
					req_q <= 1'b1;
				end
				PH_WIN, PH_LOSE: ; // Held until reset
				default: begin
					if (req_q && ack) begin
						req_q  <= 1'b0;        // Ack seen, release
						lost_q <= battle_lost; // Low outside battles
					end else if (!req_q && !ack) begin
						req_q <= 1'b1; // Block is idle again
						case (phase)
							PH_INTRO:        phase <= PH_STAGE_SCREEN;
							PH_STAGE_SCREEN: phase <= PH_BUILD;
							PH_BUILD:        phase <= PH_BATTLE;
							default: begin
								if (lost_q) begin
									phase <= PH_LOSE;
									req_q <= 1'b0;
								end else if (stage == stage_t'(NUM_STAGES - 1)) begin
									phase <= PH_WIN; // Last stage survived
									req_q <= 1'b0;
								end else begin
									stage <= stage + 2'd1;
									phase <= PH_STAGE_SCREEN;
								end
							end
						endcase
					end
				end
			endcase
		end
	end

	assign paint_req  = req_q && (phase == PH_INTRO || phase == PH_STAGE_SCREEN);
	assign build_req  = req_q && (phase == PH_BUILD);
	assign battle_req = req_q && (phase == PH_BATTLE);
	assign scene      = (phase == PH_INTRO) ? SCENE_INTRO : SCENE_STAGE;

	// At most one block is asked to work
	assert property (@(posedge clk) disable iff (!arst_n)
		$onehot0({paint_req, build_req, battle_req}));

	// A new request only once the data path has dropped every ack
	assert property (@(posedge clk) disable iff (!arst_n)
		$rose(paint_req || build_req || battle_req) |-> !(paint_ack || build_ack || battle_ack));

endmodule

// ==== common/game_pkg.sv ====
package game_pkg;

	// Frame buffer geometry
	localparam int SCREEN_W      = 160;
	localparam int SCREEN_H      = 120;
	localparam int SCREEN_PIXELS = SCREEN_W * SCREEN_H; // 19200 words

	typedef logic [14:0] coord_t;  // Row * 160 + column
	typedef logic [7:0]  xpos_t;
	typedef logic [6:0]  ypos_t;
	typedef logic [8:0]  colour_t; // RRR_GGG_BBB
	typedef logic [1:0]  stage_t;

	localparam int NUM_STAGES = 3;

	localparam colour_t COL_GRASS = 9'b000_110_000;
	localparam colour_t COL_ROAD  = 9'b011_011_011;
	localparam colour_t COL_TOWER = 9'b000_000_111;
	localparam colour_t COL_CAR   = 9'b111_000_000;
	// Border per stage, entry 2 first
	localparam colour_t [NUM_STAGES-1:0] COL_STAGE = {9'b111_000_111, 9'b111_100_000, 9'b111_111_000};

	localparam int ROAD_Y0 = 56;
	localparam int ROAD_Y1 = 63;
	localparam int CAR_ROW = ROAD_Y0 + 4; // Lane the cars drive on

	localparam int TOWER_SIZE       = 4;
	localparam int TOWERS_PER_STAGE = 2;
	localparam int MAX_TOWERS       = 6;
	localparam int CURSOR_STEP      = 8; // Cursor grid in pixels

	localparam int CAR_STEP_CYCLES = 4;
	localparam int CAR_GAP         = 20; // Steps between launches
	localparam int MAX_CARS        = 3;

	typedef logic [$clog2(CAR_STEP_CYCLES)-1:0] step_cnt_t;
	typedef logic [$clog2(CAR_GAP)-1:0]         gap_cnt_t;

	// One frame buffer write
	typedef struct packed {
		logic    wren;
		coord_t  coord;
		colour_t colour;
	} pixel_t;

	typedef enum logic {SCENE_INTRO, SCENE_STAGE} scene_t;

	typedef struct packed {
		logic [2:0]             count; // Valid entries in col
		xpos_t [MAX_TOWERS-1:0] col;   // Left column of each tower
	} tower_set_t;

	typedef enum logic [2:0] {
		PH_IDLE, PH_INTRO, PH_STAGE_SCREEN, PH_BUILD, PH_BATTLE, PH_WIN, PH_LOSE
	} phase_t;

	function automatic coord_t pix_addr(ypos_t y, xpos_t x);
		return coord_t'(y) * coord_t'(SCREEN_W) + coord_t'(x);
	endfunction

endpackage
